// ==== logic/backend_top.sv ====
module backend_top (
  input  logic               clk,
  input  logic               rst_n_i,

  input  logic               inst_valid_i,
  input  lsx_pkg::word_t     inst_pc_i,
  input  lsx_pkg::word_t     inst_i,
  input  lsx_pkg::aluop_t    aluop_i,
  input  lsx_pkg::alusel_t   alusel_i,
  input  lsx_pkg::reg_addr_t rs1_addr_i,
  input  lsx_pkg::reg_addr_t rs2_addr_i,
  input  lsx_pkg::reg_addr_t rd_addr_i,
  input  logic               wreg_i,
  input  logic               use_imm_i,
  input  lsx_pkg::word_t     imm_i,

  output logic               commit_valid_o,
  output lsx_pkg::word_t     commit_pc_o,
  output logic               commit_we_o,
  output lsx_pkg::reg_addr_t commit_waddr_o,
  output lsx_pkg::word_t     commit_wdata_o
);

  lsx_pkg::reg_addr_t rf_raddr1;
  lsx_pkg::reg_addr_t rf_raddr2;
  lsx_pkg::word_t     rf_rdata1;
  lsx_pkg::word_t     rf_rdata2;

  // issue to execute
  logic               iss_valid;
  lsx_pkg::word_t     iss_pc;
  lsx_pkg::word_t     iss_inst;
  lsx_pkg::aluop_t    iss_aluop;
  lsx_pkg::alusel_t   iss_alusel;
  lsx_pkg::reg_addr_t iss_wd;
  logic               iss_wreg;
  lsx_pkg::word_t     iss_reg1;
  lsx_pkg::word_t     iss_reg2;

  // execute to memory
  logic               ex_valid;
  lsx_pkg::word_t     ex_pc;
  lsx_pkg::reg_addr_t ex_wd;
  logic               ex_wreg;
  lsx_pkg::word_t     ex_wdata;
  lsx_pkg::aluop_t    ex_aluop;
  lsx_pkg::word_t     ex_mem_addr;
  lsx_pkg::word_t     ex_reg2;

  // memory stage bypass
  logic               m_wreg;
  lsx_pkg::reg_addr_t m_wd;
  lsx_pkg::word_t     m_wdata;
  logic               m_is_load;

  regfile u_regfile (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .raddr1_i (rf_raddr1),
    .raddr2_i (rf_raddr2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .we_i     (commit_we_o),
    .waddr_i  (commit_waddr_o),
    .wdata_i  (commit_wdata_o)
  );

  issue_stage u_issue (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_pc_i    (inst_pc_i),
    .inst_i       (inst_i),
    .aluop_i      (aluop_i),
    .alusel_i     (alusel_i),
    .rs1_addr_i   (rs1_addr_i),
    .rs2_addr_i   (rs2_addr_i),
    .rd_addr_i    (rd_addr_i),
    .wreg_i       (wreg_i),
    .use_imm_i    (use_imm_i),
    .imm_i        (imm_i),
    .rf_raddr1_o  (rf_raddr1),
    .rf_raddr2_o  (rf_raddr2),
    .rf_rdata1_i  (rf_rdata1),
    .rf_rdata2_i  (rf_rdata2),
    .ex_wreg_i    (ex_wreg),
    .ex_wd_i      (ex_wd),
    .ex_wdata_i   (ex_wdata),
    .m_wreg_i     (m_wreg),
    .m_wd_i       (m_wd),
    .m_wdata_i    (m_wdata),
    .m_is_load_i  (m_is_load),
    .wb_wreg_i    (commit_we_o),
    .wb_wd_i      (commit_waddr_o),
    .wb_wdata_i   (commit_wdata_o),
    .ex_valid_o   (iss_valid),
    .ex_pc_o      (iss_pc),
    .ex_inst_o    (iss_inst),
    .ex_aluop_o   (iss_aluop),
    .ex_alusel_o  (iss_alusel),
    .ex_wd_o      (iss_wd),
    .ex_wreg_o    (iss_wreg),
    .ex_reg1_o    (iss_reg1),
    .ex_reg2_o    (iss_reg2)
  );

  ex u_ex (
    .ex_valid_i (iss_valid),
    .pc_i       (iss_pc),
    .inst_i     (iss_inst),
    .aluop_i    (iss_aluop),
    .alusel_i   (iss_alusel),
    .wd_i       (iss_wd),
    .wreg_i     (iss_wreg),
    .reg1_i     (iss_reg1),
    .reg2_i     (iss_reg2),
    .valid_o    (ex_valid),
    .pc_o       (ex_pc),
    .wd_o       (ex_wd),
    .wreg_o     (ex_wreg),
    .wdata_o    (ex_wdata),
    .aluop_o    (ex_aluop),
    .mem_addr_o (ex_mem_addr),
    .reg2_o     (ex_reg2)
  );

  mem_stage u_mem (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (ex_valid),
    .pc_i        (ex_pc),
    .wd_i        (ex_wd),
    .wreg_i      (ex_wreg),
    .wdata_i     (ex_wdata),
    .aluop_i     (ex_aluop),
    .mem_addr_i  (ex_mem_addr),
    .reg2_i      (ex_reg2),
    .m_wreg_o    (m_wreg),
    .m_wd_o      (m_wd),
    .m_wdata_o   (m_wdata),
    .m_is_load_o (m_is_load),
    .wb_valid_o  (commit_valid_o),
    .wb_pc_o     (commit_pc_o),
    .wb_wreg_o   (commit_we_o),
    .wb_wd_o     (commit_waddr_o),
    .wb_wdata_o  (commit_wdata_o)
  );

endmodule

// ==== logic/ex.sv ====
module ex (
  input  logic               ex_valid_i,
  input  lsx_pkg::word_t     pc_i,
  input  lsx_pkg::word_t     inst_i,
  input  lsx_pkg::aluop_t    aluop_i,
  input  lsx_pkg::alusel_t   alusel_i,
  input  lsx_pkg::reg_addr_t wd_i,
  input  logic               wreg_i,
  input  lsx_pkg::word_t     reg1_i,
  input  lsx_pkg::word_t     reg2_i,

  output logic               valid_o,
  output lsx_pkg::word_t     pc_o,
  output lsx_pkg::reg_addr_t wd_o,
  output logic               wreg_o,
  output lsx_pkg::word_t     wdata_o,
  output lsx_pkg::aluop_t    aluop_o,
  output lsx_pkg::word_t     mem_addr_o,
  output lsx_pkg::word_t     reg2_o
);

  lsx_pkg::word_t logic_res;
  lsx_pkg::word_t shift_res;
  lsx_pkg::word_t move_res;
  lsx_pkg::word_t arith_res;
  lsx_pkg::word_t link_addr;
  logic [63:0]    prod_s;
  logic [63:0]    prod_u;
  logic [4:0]     shamt;

  assign valid_o = ex_valid_i;
  assign pc_o    = pc_i;
  assign wd_o    = wd_i;
  assign wreg_o  = wreg_i;
  assign aluop_o = aluop_i;
  assign reg2_o  = reg2_i;

  // base plus sign-extended 12-bit offset
  assign mem_addr_o = reg1_i + {{20{inst_i[21]}}, inst_i[21:10]};

  assign shamt     = reg2_i[4:0];
  assign link_addr = pc_i + 32'd4;

  assign prod_s = $signed({{32{reg1_i[31]}}, reg1_i}) * $signed({{32{reg2_i[31]}}, reg2_i});
  assign prod_u = {32'b0, reg1_i} * {32'b0, reg2_i};

  always_comb
  begin
    case (aluop_i)
      lsx_pkg::OP_OR:  logic_res = reg1_i | reg2_i;
      lsx_pkg::OP_AND: logic_res = reg1_i & reg2_i;
      lsx_pkg::OP_XOR: logic_res = reg1_i ^ reg2_i;
      lsx_pkg::OP_NOR: logic_res = ~(reg1_i | reg2_i);
      default:         logic_res = '0;
    endcase
  end

  always_comb
  begin
    case (aluop_i)
      lsx_pkg::OP_SLL: shift_res = reg1_i << shamt;
      lsx_pkg::OP_SRL: shift_res = reg1_i >> shamt;
      lsx_pkg::OP_SRA: shift_res = $signed(reg1_i) >>> shamt;
      default:         shift_res = '0;
    endcase
  end

  // immediate arrives on operand 2
  always_comb
  begin
    case (aluop_i)
      lsx_pkg::OP_LUI:   move_res = reg2_i;
      lsx_pkg::OP_PCADD: move_res = pc_i + reg2_i;
      default:           move_res = '0;
    endcase
  end

  always_comb
  begin
    case (aluop_i)
      lsx_pkg::OP_ADD:   arith_res = reg1_i + reg2_i;
      lsx_pkg::OP_SUB:   arith_res = reg1_i - reg2_i;
      lsx_pkg::OP_MUL:   arith_res = prod_u[31:0];
      lsx_pkg::OP_MULH:  arith_res = prod_s[63:32];
      lsx_pkg::OP_MULHU: arith_res = prod_u[63:32];
      lsx_pkg::OP_SLT:   arith_res = {31'b0, $signed(reg1_i) < $signed(reg2_i)};
      lsx_pkg::OP_SLTU:  arith_res = {31'b0, reg1_i < reg2_i};
      // zero divisor gives all ones as quotient and the dividend as remainder
      lsx_pkg::OP_DIVU:  arith_res = (reg2_i == '0) ? '1 : reg1_i / reg2_i;
      lsx_pkg::OP_MODU:  arith_res = (reg2_i == '0) ? reg1_i : reg1_i % reg2_i;
      default:           arith_res = '0;
    endcase
  end

  // loads get their data in the memory stage
  always_comb
  begin
    case (alusel_i)
      lsx_pkg::RES_LOGIC: wdata_o = logic_res;
      lsx_pkg::RES_SHIFT: wdata_o = shift_res;
      lsx_pkg::RES_MOVE:  wdata_o = move_res;
      lsx_pkg::RES_ARITH: wdata_o = arith_res;
      lsx_pkg::RES_JUMP:  wdata_o = link_addr;
      default:            wdata_o = '0;
    endcase
  end

  always_comb
  begin
    if (ex_valid_i && wreg_i)
    begin
      a_sel_set: assert (alusel_i != lsx_pkg::RES_NOP)
        else $error("ex: register write without a result group");
    end
  end

endmodule

// ==== logic/issue_stage.sv ====
module issue_stage (
  input  logic               clk,
  input  logic               rst_n_i,

  input  logic               inst_valid_i,
  input  lsx_pkg::word_t     inst_pc_i,
  input  lsx_pkg::word_t     inst_i,
  input  lsx_pkg::aluop_t    aluop_i,
  input  lsx_pkg::alusel_t   alusel_i,
  input  lsx_pkg::reg_addr_t rs1_addr_i,
  input  lsx_pkg::reg_addr_t rs2_addr_i,
  input  lsx_pkg::reg_addr_t rd_addr_i,
  input  logic               wreg_i,
  input  logic               use_imm_i,
  input  lsx_pkg::word_t     imm_i,

  output lsx_pkg::reg_addr_t rf_raddr1_o,
  output lsx_pkg::reg_addr_t rf_raddr2_o,
  input  lsx_pkg::word_t     rf_rdata1_i,
  input  lsx_pkg::word_t     rf_rdata2_i,

  input  logic               ex_wreg_i,
  input  lsx_pkg::reg_addr_t ex_wd_i,
  input  lsx_pkg::word_t     ex_wdata_i,
  input  logic               m_wreg_i,
  input  lsx_pkg::reg_addr_t m_wd_i,
  input  lsx_pkg::word_t     m_wdata_i,
  input  logic               m_is_load_i,
  input  logic               wb_wreg_i,
  input  lsx_pkg::reg_addr_t wb_wd_i,
  input  lsx_pkg::word_t     wb_wdata_i,

  output logic               ex_valid_o,
  output lsx_pkg::word_t     ex_pc_o,
  output lsx_pkg::word_t     ex_inst_o,
  output lsx_pkg::aluop_t    ex_aluop_o,
  output lsx_pkg::alusel_t   ex_alusel_o,
  output lsx_pkg::reg_addr_t ex_wd_o,
  output logic               ex_wreg_o,
  output lsx_pkg::word_t     ex_reg1_o,
  output lsx_pkg::word_t     ex_reg2_o
);

  lsx_pkg::word_t src1;
  lsx_pkg::word_t src2;
  logic           is_store;
  logic           rs2_used;

  // youngest producer wins
  function automatic lsx_pkg::word_t bypass(input lsx_pkg::reg_addr_t addr,
                                            input lsx_pkg::word_t     rf_val);
    if (addr == '0)
      return '0;
    else if (ex_wreg_i && (ex_wd_i == addr))
      return ex_wdata_i;
    else if (m_wreg_i && (m_wd_i == addr))
      return m_wdata_i;
    else if (wb_wreg_i && (wb_wd_i == addr))
      return wb_wdata_i;
    else
      return rf_val;
  endfunction

  assign rf_raddr1_o = rs1_addr_i;
  assign rf_raddr2_o = rs2_addr_i;

  always_comb
  begin
    src1 = bypass(rs1_addr_i, rf_rdata1_i);
    src2 = bypass(rs2_addr_i, rf_rdata2_i);
  end

  // stores keep rs2 as data
  assign is_store = (aluop_i == lsx_pkg::OP_ST_W);
  assign rs2_used = !use_imm_i || is_store;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ex_valid_o  <= 1'b0;
      ex_wreg_o   <= 1'b0;
      ex_wd_o     <= '0;
      ex_aluop_o  <= '0;
      ex_alusel_o <= lsx_pkg::RES_NOP;
    end
    else
    begin
      ex_valid_o  <= inst_valid_i;
      ex_wreg_o   <= inst_valid_i && wreg_i;
      ex_wd_o     <= rd_addr_i;
      ex_aluop_o  <= aluop_i;
      ex_alusel_o <= alusel_i;
    end
  end

  always_ff @(posedge clk)
  begin
    ex_pc_o   <= inst_pc_i;
    ex_inst_o <= inst_i;
    ex_reg1_o <= src1;
    ex_reg2_o <= rs2_used ? src2 : imm_i;
  end

  // load data only exists from the memory stage on, so the ex bypass would be stale
  a_no_load_use: assert property (@(posedge clk) disable iff (!rst_n_i)
    (ex_valid_o && m_is_load_i && m_wreg_i && (m_wd_i != '0)) |->
      (($past(rs1_addr_i) != m_wd_i) &&
       (!$past(rs2_used) || ($past(rs2_addr_i) != m_wd_i))));

endmodule

// ==== logic/lsx_pkg.sv ====
package lsx_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  aluop_t;
  typedef logic [2:0]  alusel_t;

  // data ram geometry
  localparam int DMEM_WORDS = 64;
  typedef logic [5:0] dmem_addr_t;

  // logic group
  localparam aluop_t OP_OR    = 8'h25;
  localparam aluop_t OP_AND   = 8'h24;
  localparam aluop_t OP_XOR   = 8'h26;
  localparam aluop_t OP_NOR   = 8'h27;

  // shift group
  localparam aluop_t OP_SLL   = 8'h7c;
  localparam aluop_t OP_SRL   = 8'h02;
  localparam aluop_t OP_SRA   = 8'h03;

  // arithmetic group
  localparam aluop_t OP_ADD   = 8'h20;
  localparam aluop_t OP_SUB   = 8'h22;
  localparam aluop_t OP_MUL   = 8'h18;
  localparam aluop_t OP_MULH  = 8'h19;
  localparam aluop_t OP_MULHU = 8'h1a;
  localparam aluop_t OP_DIVU  = 8'h1b;
  localparam aluop_t OP_MODU  = 8'h1c;
  localparam aluop_t OP_SLT   = 8'h2a;
  localparam aluop_t OP_SLTU  = 8'h2b;

  // move group
  localparam aluop_t OP_LUI   = 8'h5c;
  localparam aluop_t OP_PCADD = 8'h5d;

  // memory and control flow
  localparam aluop_t OP_LD_W  = 8'he3;
  localparam aluop_t OP_ST_W  = 8'heb;
  localparam aluop_t OP_JUMP  = 8'h50;

  // result group selects
  localparam alusel_t RES_NOP   = 3'b000;
  localparam alusel_t RES_LOGIC = 3'b001;
  localparam alusel_t RES_SHIFT = 3'b010;
  localparam alusel_t RES_MOVE  = 3'b011;
  localparam alusel_t RES_ARITH = 3'b100;
  localparam alusel_t RES_JUMP  = 3'b101;
  localparam alusel_t RES_LOAD  = 3'b110;

endpackage

// ==== logic/mem_stage.sv ====
module mem_stage (
  input  logic               clk,
  input  logic               rst_n_i,

  input  logic               valid_i,
  input  lsx_pkg::word_t     pc_i,
  input  lsx_pkg::reg_addr_t wd_i,
  input  logic               wreg_i,
  input  lsx_pkg::word_t     wdata_i,
  input  lsx_pkg::aluop_t    aluop_i,
  input  lsx_pkg::word_t     mem_addr_i,
  input  lsx_pkg::word_t     reg2_i,

  output logic               m_wreg_o,
  output lsx_pkg::reg_addr_t m_wd_o,
  output lsx_pkg::word_t     m_wdata_o,
  output logic               m_is_load_o,

  output logic               wb_valid_o,
  output lsx_pkg::word_t     wb_pc_o,
  output logic               wb_wreg_o,
  output lsx_pkg::reg_addr_t wb_wd_o,
  output lsx_pkg::word_t     wb_wdata_o
);

  logic                m_valid;
  lsx_pkg::word_t      m_pc;
  lsx_pkg::aluop_t     m_aluop;
  lsx_pkg::word_t      m_result;
  lsx_pkg::word_t      m_addr;
  lsx_pkg::word_t      m_store_data;
  lsx_pkg::dmem_addr_t m_idx;
  logic                store_en;

  lsx_pkg::word_t dmem [lsx_pkg::DMEM_WORDS];

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      m_valid  <= 1'b0;
      m_wreg_o <= 1'b0;
      m_wd_o   <= '0;
      m_aluop  <= '0;
    end
    else
    begin
      m_valid  <= valid_i;
      m_wreg_o <= wreg_i;
      m_wd_o   <= wd_i;
      m_aluop  <= aluop_i;
    end
  end

  always_ff @(posedge clk)
  begin
    m_pc         <= pc_i;
    m_result     <= wdata_i;
    m_addr       <= mem_addr_i;
    m_store_data <= reg2_i;
  end

  assign m_idx       = m_addr[7:2];
  assign m_is_load_o = m_valid && (m_aluop == lsx_pkg::OP_LD_W);
  assign store_en    = m_valid && (m_aluop == lsx_pkg::OP_ST_W);
  assign m_wdata_o   = m_is_load_o ? dmem[m_idx] : m_result;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < lsx_pkg::DMEM_WORDS; i++)
      begin
        dmem[i] <= '0;
      end
    end
    else if (store_en)
    begin
      dmem[m_idx] <= m_store_data;
    end
  end

  // commit register
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wb_valid_o <= 1'b0;
      wb_wreg_o  <= 1'b0;
      wb_wd_o    <= '0;
    end
    else
    begin
      wb_valid_o <= m_valid;
      wb_wreg_o  <= m_wreg_o;
      wb_wd_o    <= m_wd_o;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_pc_o    <= m_pc;
    wb_wdata_o <= m_wdata_o;
  end

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    (m_is_load_o || store_en) |-> (m_addr[1:0] == 2'b00));

endmodule

// ==== logic/regfile.sv ====
module regfile (
  input  logic               clk,
  input  logic               rst_n_i,

  input  lsx_pkg::reg_addr_t raddr1_i,
  input  lsx_pkg::reg_addr_t raddr2_i,
  output lsx_pkg::word_t     rdata1_o,
  output lsx_pkg::word_t     rdata2_o,

  input  logic               we_i,
  input  lsx_pkg::reg_addr_t waddr_i,
  input  lsx_pkg::word_t     wdata_i
);

  // r0 has no storage
  lsx_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  // write port driven from the writeback register
  a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    we_i |-> !$isunknown(waddr_i));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the backend testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_backend -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_backend)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// ==== sim.f ====
logic/lsx_pkg.sv
logic/regfile.sv
logic/issue_stage.sv
logic/ex.sv
logic/mem_stage.sv
logic/backend_top.sv
sim/tb_backend.sv

// ==== sim/tb_backend.sv ====
module tb_backend;

  logic               clk;
  logic               rst_n_i;
  logic               inst_valid_i;
  lsx_pkg::word_t     inst_pc_i;
  lsx_pkg::word_t     inst_i;
  lsx_pkg::aluop_t    aluop_i;
  lsx_pkg::alusel_t   alusel_i;
  lsx_pkg::reg_addr_t rs1_addr_i;
  lsx_pkg::reg_addr_t rs2_addr_i;
  lsx_pkg::reg_addr_t rd_addr_i;
  logic               wreg_i;
  logic               use_imm_i;
  lsx_pkg::word_t     imm_i;
  logic               commit_valid_o;
  lsx_pkg::word_t     commit_pc_o;
  logic               commit_we_o;
  lsx_pkg::reg_addr_t commit_waddr_o;
  lsx_pkg::word_t     commit_wdata_o;

  // reference model state
  lsx_pkg::word_t model_regs [32];
  lsx_pkg::word_t model_mem [lsx_pkg::DMEM_WORDS];
  lsx_pkg::word_t next_pc;
  string          test_name;
  int             issued;
  int             cycles;
  int             mismatches;
  int             failures;

  // expected commits in issue order
  lsx_pkg::word_t     q_pc [$];
  logic               q_we [$];
  lsx_pkg::reg_addr_t q_waddr [$];
  lsx_pkg::word_t     q_wdata [$];
  string              q_test [$];

  backend_top u_dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_pc_i      (inst_pc_i),
    .inst_i         (inst_i),
    .aluop_i        (aluop_i),
    .alusel_i       (alusel_i),
    .rs1_addr_i     (rs1_addr_i),
    .rs2_addr_i     (rs2_addr_i),
    .rd_addr_i      (rd_addr_i),
    .wreg_i         (wreg_i),
    .use_imm_i      (use_imm_i),
    .imm_i          (imm_i),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_we_o    (commit_we_o),
    .commit_waddr_o (commit_waddr_o),
    .commit_wdata_o (commit_wdata_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
  end

  function automatic lsx_pkg::alusel_t result_sel(input lsx_pkg::aluop_t op);
    case (op)
      lsx_pkg::OP_OR, lsx_pkg::OP_AND, lsx_pkg::OP_XOR, lsx_pkg::OP_NOR:
        return lsx_pkg::RES_LOGIC;
      lsx_pkg::OP_SLL, lsx_pkg::OP_SRL, lsx_pkg::OP_SRA:
        return lsx_pkg::RES_SHIFT;
      lsx_pkg::OP_LUI, lsx_pkg::OP_PCADD:
        return lsx_pkg::RES_MOVE;
      lsx_pkg::OP_JUMP:
        return lsx_pkg::RES_JUMP;
      lsx_pkg::OP_LD_W:
        return lsx_pkg::RES_LOAD;
      lsx_pkg::OP_ST_W:
        return lsx_pkg::RES_NOP;
      default:
        return lsx_pkg::RES_ARITH;
    endcase
  endfunction

  // ISA-level result of one operation
  function automatic lsx_pkg::word_t model_result(input lsx_pkg::aluop_t op,
                                                  input lsx_pkg::word_t a,
                                                  input lsx_pkg::word_t b,
                                                  input lsx_pkg::word_t pc);
    longint          sa;
    longint          sb;
    longint          sprod;
    longint unsigned ua;
    longint unsigned ub;
    longint unsigned uprod;
    int              sh;
    sa    = $signed(a);
    sb    = $signed(b);
    sprod = sa * sb;
    ua    = a;
    ub    = b;
    uprod = ua * ub;
    sh    = int'(b[4:0]);
    case (op)
      lsx_pkg::OP_OR:    return a | b;
      lsx_pkg::OP_AND:   return a & b;
      lsx_pkg::OP_XOR:   return a ^ b;
      lsx_pkg::OP_NOR:   return ~(a | b);
      lsx_pkg::OP_SLL:   return a << sh;
      lsx_pkg::OP_SRL:   return a >> sh;
      lsx_pkg::OP_SRA:   return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      lsx_pkg::OP_ADD:   return a + b;
      lsx_pkg::OP_SUB:   return a - b;
      lsx_pkg::OP_MUL:   return uprod[31:0];
      lsx_pkg::OP_MULH:  return sprod[63:32];
      lsx_pkg::OP_MULHU: return uprod[63:32];
      lsx_pkg::OP_SLT:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      lsx_pkg::OP_SLTU:  return {31'b0, a < b};
      lsx_pkg::OP_DIVU:  return (b == 32'h0) ? 32'hffff_ffff : a / b;
      lsx_pkg::OP_MODU:  return (b == 32'h0) ? a : a % b;
      lsx_pkg::OP_LUI:   return b;
      lsx_pkg::OP_PCADD: return pc + b;
      lsx_pkg::OP_JUMP:  return pc + 32'd4;
      default:           return 32'h0;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input string field,
                                 input lsx_pkg::word_t exp, input lsx_pkg::word_t act);
    mismatches++;
    $display("mismatch %s %s: expected %h, actual %h", name, field, exp, act);
  endtask

  task automatic check_commit(input string name, input lsx_pkg::word_t pc, input logic we,
                              input lsx_pkg::reg_addr_t waddr, input lsx_pkg::word_t wdata);
    if (commit_pc_o !== pc)
      report_mismatch(name, "pc", pc, commit_pc_o);
    if (commit_we_o !== we)
      report_mismatch(name, "we", {31'b0, we}, {31'b0, commit_we_o});
    if (we && (commit_waddr_o !== waddr))
      report_mismatch(name, "waddr", {27'b0, waddr}, {27'b0, commit_waddr_o});
    if (we && (commit_wdata_o !== wdata))
      report_mismatch(name, "wdata", wdata, commit_wdata_o);
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk)
  begin
    if (rst_n_i && commit_valid_o)
    begin
      if (q_pc.size() == 0)
      begin
        failures++;
        $display("commit from pc %h arrived with no instruction outstanding", commit_pc_o);
      end
      else
      begin
        check_commit(q_test.pop_front(), q_pc.pop_front(), q_we.pop_front(),
                     q_waddr.pop_front(), q_wdata.pop_front());
      end
    end
  end

  task automatic issue_op(input lsx_pkg::aluop_t op, input lsx_pkg::reg_addr_t rs1,
                          input lsx_pkg::reg_addr_t rs2, input lsx_pkg::reg_addr_t rd,
                          input logic wreg, input logic use_imm, input lsx_pkg::word_t imm,
                          input logic [11:0] offset);
    lsx_pkg::word_t a;
    lsx_pkg::word_t b;
    lsx_pkg::word_t addr;
    lsx_pkg::word_t res;
    a    = model_regs[rs1];
    b    = (use_imm && (op != lsx_pkg::OP_ST_W)) ? imm : model_regs[rs2];
    addr = a + {{20{offset[11]}}, offset};
    if (op == lsx_pkg::OP_LD_W)
      res = model_mem[addr[7:2]];
    else
      res = model_result(op, a, b, next_pc);
    if (op == lsx_pkg::OP_ST_W)
      model_mem[addr[7:2]] = b;
    @(posedge clk);
    #2;
    inst_valid_i = 1'b1;
    inst_pc_i    = next_pc;
    inst_i       = {10'b0, offset, 10'b0};
    aluop_i      = op;
    alusel_i     = result_sel(op);
    rs1_addr_i   = rs1;
    rs2_addr_i   = rs2;
    rd_addr_i    = rd;
    wreg_i       = wreg;
    use_imm_i    = use_imm;
    imm_i        = imm;
    q_test.push_back(test_name);
    q_pc.push_back(next_pc);
    q_we.push_back(wreg);
    q_waddr.push_back(rd);
    q_wdata.push_back(res);
    if (wreg && (rd != 5'd0))
      model_regs[rd] = res;
    next_pc = next_pc + 32'd4;
    issued++;
  endtask

  task automatic reg_op(input lsx_pkg::aluop_t op, input lsx_pkg::reg_addr_t rd,
                        input lsx_pkg::reg_addr_t rs1, input lsx_pkg::reg_addr_t rs2);
    issue_op(op, rs1, rs2, rd, 1'b1, 1'b0, 32'h0, 12'h0);
  endtask

  task automatic imm_op(input lsx_pkg::aluop_t op, input lsx_pkg::reg_addr_t rd,
                        input lsx_pkg::reg_addr_t rs1, input lsx_pkg::word_t imm);
    issue_op(op, rs1, 5'd0, rd, 1'b1, 1'b1, imm, 12'h0);
  endtask

  task automatic set_reg(input lsx_pkg::reg_addr_t rd, input lsx_pkg::word_t val);
    imm_op(lsx_pkg::OP_LUI, rd, 5'd0, val);
  endtask

  task automatic store_word(input lsx_pkg::reg_addr_t data, input lsx_pkg::reg_addr_t base,
                            input logic [11:0] offset);
    issue_op(lsx_pkg::OP_ST_W, base, data, 5'd0, 1'b0, 1'b1, 32'h0, offset);
  endtask

  task automatic load_word(input lsx_pkg::reg_addr_t rd, input lsx_pkg::reg_addr_t base,
                           input logic [11:0] offset);
    issue_op(lsx_pkg::OP_LD_W, base, 5'd0, rd, 1'b1, 1'b1, 32'h0, offset);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
      inst_valid_i = 1'b0;
      rs1_addr_i   = 5'd0;
      rs2_addr_i   = 5'd0;
      wreg_i       = 1'b0;
      use_imm_i    = 1'b0;
    end
  endtask

  // wait until every expected commit is checked
  task automatic drain;
    idle(1);
    while (q_pc.size() != 0)
      @(negedge clk);
  endtask

  task automatic check_reset;
    test_name = "reset";
    rst_n_i = 1'b0;
    repeat (2)
    begin
      @(posedge clk);
      #2;
      if (commit_valid_o !== 1'b0)
      begin
        failures++;
        $display("reset: commit_valid_o is high while reset is asserted");
      end
    end
    rst_n_i = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      if (commit_valid_o !== 1'b0)
      begin
        failures++;
        $display("reset: commit_valid_o is high with nothing issued");
      end
    end
  endtask

  task automatic logic_shift_ops;
    lsx_pkg::aluop_t ops [7];
    test_name = "logic_shift";
    ops = '{lsx_pkg::OP_OR, lsx_pkg::OP_AND, lsx_pkg::OP_XOR, lsx_pkg::OP_NOR,
            lsx_pkg::OP_SLL, lsx_pkg::OP_SRL, lsx_pkg::OP_SRA};
    set_reg(5'd1, $urandom);
    set_reg(5'd2, $urandom);
    foreach (ops[i])
    begin
      reg_op(ops[i], 5'd3, 5'd1, 5'd2);
      imm_op(ops[i], 5'd4, 5'd1, $urandom);
      reg_op(ops[i], 5'd5, 5'd3, 5'd4);
    end
    // r0 keeps reading zero after a write
    reg_op(lsx_pkg::OP_OR, 5'd0, 5'd1, 5'd2);
    reg_op(lsx_pkg::OP_OR, 5'd6, 5'd0, 5'd0);
    reg_op(lsx_pkg::OP_ADD, 5'd7, 5'd0, 5'd1);
    drain();
  endtask

  task automatic arith_ops;
    lsx_pkg::aluop_t ops [9];
    test_name = "arith";
    ops = '{lsx_pkg::OP_ADD, lsx_pkg::OP_SUB, lsx_pkg::OP_MUL, lsx_pkg::OP_MULH,
            lsx_pkg::OP_MULHU, lsx_pkg::OP_SLT, lsx_pkg::OP_SLTU, lsx_pkg::OP_DIVU,
            lsx_pkg::OP_MODU};
    set_reg(5'd1, $urandom | 32'h8000_0000);
    set_reg(5'd2, $urandom & 32'h7fff_ffff);
    set_reg(5'd3, ($urandom & 32'hff) + 32'd1);
    foreach (ops[i])
    begin
      reg_op(ops[i], 5'd4, 5'd1, 5'd2);
      reg_op(ops[i], 5'd5, 5'd2, 5'd1);
      reg_op(ops[i], 5'd6, 5'd1, 5'd3);
    end
    // zero divisor from r0 and from the immediate
    reg_op(lsx_pkg::OP_DIVU, 5'd7, 5'd1, 5'd0);
    reg_op(lsx_pkg::OP_MODU, 5'd7, 5'd1, 5'd0);
    imm_op(lsx_pkg::OP_DIVU, 5'd8, 5'd2, 32'h0);
    imm_op(lsx_pkg::OP_MODU, 5'd8, 5'd2, 32'h0);
    set_reg(5'd9, $urandom | 32'h8000_0000);
    reg_op(lsx_pkg::OP_SLT, 5'd10, 5'd1, 5'd9);
    reg_op(lsx_pkg::OP_SLTU, 5'd10, 5'd9, 5'd1);
    drain();
  endtask

  task automatic dependent_chains;
    lsx_pkg::aluop_t ops [8];
    lsx_pkg::word_t  r;
    test_name = "bypass_chain";
    ops = '{lsx_pkg::OP_ADD, lsx_pkg::OP_SUB, lsx_pkg::OP_XOR, lsx_pkg::OP_OR,
            lsx_pkg::OP_AND, lsx_pkg::OP_SLTU, lsx_pkg::OP_MUL, lsx_pkg::OP_NOR};
    imm_op(lsx_pkg::OP_ADD, 5'd10, 5'd0, $urandom);
    imm_op(lsx_pkg::OP_ADD, 5'd11, 5'd10, $urandom);
    reg_op(lsx_pkg::OP_ADD, 5'd12, 5'd10, 5'd11);
    reg_op(lsx_pkg::OP_SUB, 5'd13, 5'd10, 5'd12);
    reg_op(lsx_pkg::OP_XOR, 5'd14, 5'd10, 5'd11);
    // the younger of two writes to one register must win
    imm_op(lsx_pkg::OP_ADD, 5'd15, 5'd0, $urandom);
    imm_op(lsx_pkg::OP_ADD, 5'd15, 5'd15, $urandom);
    reg_op(lsx_pkg::OP_ADD, 5'd16, 5'd15, 5'd15);
    for (int i = 0; i < 24; i++)
    begin
      r = $urandom;
      reg_op(ops[r[2:0]], {3'b010, r[4:3]}, {3'b010, r[6:5]}, {3'b010, r[8:7]});
    end
    drain();
  endtask

  task automatic store_load_pairs;
    lsx_pkg::word_t r;
    logic [11:0]    off_st;
    logic [11:0]    off_ld;
    test_name = "load_store";
    set_reg(5'd20, 32'h0000_0080);
    set_reg(5'd21, $urandom);
    set_reg(5'd22, $urandom);
    store_word(5'd21, 5'd20, 12'd8);
    store_word(5'd22, 5'd20, 12'hff0);
    load_word(5'd23, 5'd20, 12'd8);
    load_word(5'd24, 5'd20, 12'hff0);
    imm_op(lsx_pkg::OP_ADD, 5'd25, 5'd21, 32'd1);
    reg_op(lsx_pkg::OP_ADD, 5'd26, 5'd23, 5'd24);
    load_word(5'd27, 5'd20, 12'd4);
    for (int i = 0; i < 6; i++)
    begin
      r      = $urandom;
      off_st = {6'b0, r[3:0], 2'b00} - 12'd32;
      off_ld = {6'b0, r[7:4], 2'b00} - 12'd32;
      store_word(r[8] ? 5'd22 : 5'd21, 5'd20, off_st);
      load_word(5'd28, 5'd20, off_ld);
      reg_op(lsx_pkg::OP_ADD, 5'd21, 5'd21, 5'd22);
      reg_op(lsx_pkg::OP_XOR, 5'd29, 5'd28, 5'd21);
    end
    drain();
  endtask

  task automatic move_and_link;
    test_name = "move_jump";
    next_pc = $urandom & 32'hffff_fffc;
    imm_op(lsx_pkg::OP_LUI, 5'd12, 5'd0, $urandom);
    imm_op(lsx_pkg::OP_PCADD, 5'd13, 5'd0, $urandom);
    imm_op(lsx_pkg::OP_PCADD, 5'd13, 5'd0, 32'hffff_fff0);
    issue_op(lsx_pkg::OP_JUMP, 5'd0, 5'd0, 5'd1, 1'b1, 1'b0, 32'h0, 12'h0);
    reg_op(lsx_pkg::OP_ADD, 5'd14, 5'd1, 5'd13);
    issue_op(lsx_pkg::OP_JUMP, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'h0, 12'h0);
    reg_op(lsx_pkg::OP_OR, 5'd15, 5'd12, 5'd1);
    drain();
  endtask

  // budget grows with every issued instruction
  initial
  begin
    wait (cycles > 20 * issued + 200);
    $display("timeout: commits stopped after %0d cycles, %0d issued", cycles, issued);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    void'($urandom(33885));
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_pc_i    = 32'h0;
    inst_i       = 32'h0;
    aluop_i      = 8'h0;
    alusel_i     = lsx_pkg::RES_NOP;
    rs1_addr_i   = 5'd0;
    rs2_addr_i   = 5'd0;
    rd_addr_i    = 5'd0;
    wreg_i       = 1'b0;
    use_imm_i    = 1'b0;
    imm_i        = 32'h0;
    next_pc      = 32'h1c00_0000;
    for (int i = 0; i < 32; i++)
      model_regs[i] = 32'h0;
    for (int i = 0; i < lsx_pkg::DMEM_WORDS; i++)
      model_mem[i] = 32'h0;

    check_reset();
    logic_shift_ops();
    arith_ops();
    dependent_chains();
    store_load_pairs();
    move_and_link();
    idle(4);

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if ((mismatches + failures) == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
